//--- tb.f
verilog/uart_pkg.sv
verilog/baud_gen.sv
verilog/uart_tx.sv
verilog/rx_deframer.sv
verilog/rx_holding.sv
verilog/uart_top.sv
tests/uart_tb.sv

//--- tests/uart_tb.sv
module uart_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // DUT sizing as built with its default parameters
  localparam int CLOCK_FACTOR  = 16;
  localparam int PRESCALE_NDIV = 5;
  localparam int DDS_BITS      = 6;
  // start bit, eight data bits and one stop bit
  localparam int FRAME_BITS    = 10;
  localparam int NUM_ROWS      = 9;

  // row modes of the stimulus table
  localparam int MODE_LOOPBACK = 0;
  localparam int MODE_GLITCH   = 1;
  localparam int MODE_ALL_LOW  = 2;
  localparam int MODE_BAD_STOP = 3;

  logic       clk;
  logic       reset;
  logic [2:0] rate_select;
  logic       load;
  logic [7:0] tx_data;
  logic       load_request;
  logic       txd;
  logic       rxd;
  logic       read;
  logic [7:0] rx_data;
  logic       data_ready;
  logic       error_over_run;
  logic       error_under_run;
  logic       error_all_low;

  // rxd either follows txd or comes from the serial driver
  logic       loopback;
  logic       rxd_drive;

  int         error_count;
  int         row_count;
  int         watchdog_clocks;
  bit         table_built;
  integer     seed;

  // stimulus table, flags are {over_run, under_run, all_low}
  int         row_mode   [NUM_ROWS];
  logic [2:0] row_rate   [NUM_ROWS];
  logic [7:0] row_data   [NUM_ROWS];
  logic [7:0] row_expect [NUM_ROWS];
  logic [2:0] row_flags  [NUM_ROWS];

  assign rxd = loopback ? txd : rxd_drive;

  uart_top uut (
    .clk             (clk),
    .reset           (reset),
    .rate_select     (rate_select),
    .load            (load),
    .tx_data         (tx_data),
    .load_request    (load_request),
    .txd             (txd),
    .rxd             (rxd),
    .read            (read),
    .rx_data         (rx_data),
    .data_ready      (data_ready),
    .error_over_run  (error_over_run),
    .error_under_run (error_under_run),
    .error_all_low   (error_all_low)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // rate table and helpers
  // ------------------------------

  // DDS phase step per prescaled clock for each rate index
  function automatic int rate_increment(input logic [2:0] rate);
    case (rate)
      3'b000:  return 1;
      3'b001:  return 2;
      3'b010:  return 4;
      3'b011:  return 6;
      default: return 12;
    endcase
  endfunction

  // one bit lasts CLOCK_FACTOR mean tick spacings, rounded to whole clocks
  function automatic int bit_clocks(input logic [2:0] rate);
    int inc;
    inc = rate_increment(rate);
    return (PRESCALE_NDIV * (1 << DDS_BITS) * CLOCK_FACTOR + inc / 2) / inc;
  endfunction

  function automatic logic [2:0] flags_now();
    return {error_over_run, error_under_run, error_all_low};
  endfunction

  task automatic add_row(input int mode, input logic [2:0] rate, input logic [7:0] data,
                         input logic [7:0] expect_data, input logic [2:0] flags);
    row_mode[row_count]   = mode;
    row_rate[row_count]   = rate;
    row_data[row_count]   = data;
    row_expect[row_count] = expect_data;
    row_flags[row_count]  = flags;
    row_count++;
  endtask

  task automatic report_value(input string what, input int actual, input int expected);
    error_count++;
    $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
  endtask

  // ------------------------------
  // drivers
  // ------------------------------

  // every driver returns 1 ns after a rising edge
  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic pulse_load(input logic [7:0] value);
    @(posedge clk);
    #1;
    load    = 1'b1;
    tx_data = value;
    @(posedge clk);
    #1 load = 1'b0;
  endtask

  task automatic pulse_read();
    @(posedge clk);
    #1 read = 1'b1;
    @(posedge clk);
    #1 read = 1'b0;
  endtask

  // one full frame on rxd, least significant data bit first
  task automatic send_frame(input logic [7:0] value, input logic stop_value, input int clocks);
    logic [9:0] frame;
    frame = {stop_value, value, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rxd_drive = frame[i];
      repeat (clocks) @(posedge clk);
      #1;
    end
    rxd_drive = 1'b1;
  endtask

  task automatic send_glitch(input int clocks);
    rxd_drive = 1'b0;
    repeat (clocks) @(posedge clk);
    #1 rxd_drive = 1'b1;
  endtask

  // ------------------------------
  // waits with timeouts
  // ------------------------------

  task automatic wait_load_request(input int max_clocks, output bit seen);
    int n;
    n    = 0;
    seen = load_request;
    while (!seen && n < max_clocks)
    begin
      @(posedge clk);
      #1;
      n++;
      seen = load_request;
    end
  endtask

  task automatic wait_data_ready(input int max_clocks, output bit seen);
    int n;
    n    = 0;
    seen = data_ready;
    while (!seen && n < max_clocks)
    begin
      @(posedge clk);
      #1;
      n++;
      seen = data_ready;
    end
  endtask

  task automatic wait_flags(input logic [2:0] flags, input int max_clocks, output bit seen);
    int n;
    n    = 0;
    seen = (flags_now() == flags);
    while (!seen && n < max_clocks)
    begin
      @(posedge clk);
      #1;
      n++;
      seen = (flags_now() == flags);
    end
  endtask

  // ------------------------------
  // checks
  // ------------------------------

  task automatic check_reset_state();
    if (txd !== 1'b1)
      report_value("txd after reset", txd, 1);
    if (load_request !== 1'b1)
      report_value("load_request after reset", load_request, 1);
    if (data_ready !== 1'b0)
      report_value("data_ready after reset", data_ready, 0);
    if (flags_now() !== 3'b000)
      report_value("error flags after reset", flags_now(), 0);
  endtask

  // transmitter output looped to the receiver, then a held word and a read
  task automatic run_loopback_row(input int r);
    int frame_clocks;
    bit seen;
    frame_clocks = FRAME_BITS * bit_clocks(row_rate[r]);
    loopback     = 1'b1;
    rate_select  = row_rate[r];
    wait_load_request(frame_clocks * 2, seen);
    if (!seen)
    begin
      error_count++;
      $display("row %0d: load_request never rose, the transmitter did not free up", r);
    end
    pulse_load(row_data[r]);
    if (load_request !== 1'b0)
      report_value("load_request after load", load_request, 0);
    wait_data_ready(frame_clocks * 3, seen);
    if (!seen)
    begin
      error_count++;
      $display("row %0d: data_ready never rose, no word came back from the loop", r);
      return;
    end
    if (rx_data !== row_expect[r])
      report_value("rx_data", rx_data, row_expect[r]);
    if (flags_now() !== row_flags[r])
      report_value("error flags", flags_now(), row_flags[r]);
    // the word must wait for the reader
    repeat (25) @(posedge clk);
    #1;
    if (data_ready !== 1'b1)
      report_value("data_ready before read", data_ready, 1);
    if (rx_data !== row_expect[r])
      report_value("rx_data before read", rx_data, row_expect[r]);
    pulse_read();
    if (data_ready !== 1'b0)
      report_value("data_ready after read", data_ready, 0);
  endtask

  // the serial driver feeds a broken frame after a fresh reset
  task automatic run_error_row(input int r);
    int clocks;
    bit seen;
    clocks      = bit_clocks(row_rate[r]);
    loopback    = 1'b0;
    rxd_drive   = 1'b1;
    rate_select = row_rate[r];
    apply_reset();
    check_reset_state();
    case (row_mode[r])
      MODE_GLITCH:   send_glitch(clocks / 4);
      MODE_ALL_LOW:  send_frame(8'h00, 1'b0, clocks);
      default:       send_frame(row_data[r], 1'b0, clocks);
    endcase
    wait_flags(row_flags[r], clocks * 2, seen);
    if (!seen)
    begin
      error_count++;
      $display("row %0d: the expected error flag never came up, flags are %b", r, flags_now());
    end
    // flags hold until the next reset and no word is delivered
    repeat (clocks * 2) @(posedge clk);
    #1;
    if (flags_now() !== row_flags[r])
      report_value("error flags after hold", flags_now(), row_flags[r]);
    if (data_ready !== 1'b0)
      report_value("data_ready after a bad frame", data_ready, 0);
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------

  initial
  begin
    int rnd;
    int total;
    reset       = 1'b1;
    rate_select = 3'b000;
    load        = 1'b0;
    tx_data     = 8'h00;
    read        = 1'b0;
    loopback    = 1'b1;
    rxd_drive   = 1'b1;
    error_count = 0;
    row_count   = 0;
    table_built = 1'b0;
    seed        = 32'hb977;

    add_row(MODE_LOOPBACK, 3'b000, 8'ha5, 8'ha5, 3'b000);
    add_row(MODE_LOOPBACK, 3'b011, 8'h3c, 8'h3c, 3'b000);
    add_row(MODE_LOOPBACK, 3'b100, 8'h81, 8'h81, 3'b000);
    for (int i = 0; i < 3; i++)
    begin
      rnd = $random(seed);
      add_row(MODE_LOOPBACK, (i == 1) ? 3'b011 : 3'b100, rnd[7:0], rnd[7:0], 3'b000);
    end
    add_row(MODE_GLITCH,   3'b100, 8'h00, 8'h00, 3'b010);
    add_row(MODE_BAD_STOP, 3'b011, 8'h5a, 8'h00, 3'b100);
    add_row(MODE_ALL_LOW,  3'b100, 8'h00, 8'h00, 3'b001);

    total = 0;
    for (int r = 0; r < row_count; r++)
      total += FRAME_BITS * bit_clocks(row_rate[r]);
    watchdog_clocks = total * 3 + 5000;
    table_built     = 1'b1;

    apply_reset();
    check_reset_state();
    for (int r = 0; r < row_count; r++)
    begin
      if (row_mode[r] == MODE_LOOPBACK)
        run_loopback_row(r);
      else
        run_error_row(r);
    end

    $display("rows run: %0d, errors: %0d", row_count, error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    wait (table_built);
    repeat (watchdog_clocks) @(posedge clk);
    $display("watchdog expired after %0d clocks, the run did not finish", watchdog_clocks);
    $display("tests failed");
    $finish;
  end

endmodule

//--- verilog/baud_gen.sv
module baud_gen
  import uart_pkg::*;
#(
  parameter int PRESCALE_NDIV = 5
)
(
  input  logic      clk,
  input  logic      reset,
  input  rate_sel_t rate_select,
  output logic      baud_tick
);

  // last count of the prescaler before it wraps
  localparam logic [PRESCALE_BITS-1:0] PRESCALE_LAST = PRESCALE_BITS'(PRESCALE_NDIV - 1);

  logic [PRESCALE_BITS-1:0] prescale_count;
  logic                     dds_enable;
  dds_inc_t                 phase_inc;
  logic [DDS_BITS-1:0]      phase;
  logic                     phase_msb;
  logic                     phase_msb_d;

  // ------------------------------
  // prescaler
  // ------------------------------

  // divides the system clock by PRESCALE_NDIV
  // the DDS only advances on the clock where the count wraps
  always_ff @(posedge clk)
  begin
    if (reset)
      prescale_count <= '0;
    else if (dds_enable)
      prescale_count <= '0;
    else
      prescale_count <= prescale_count + 1'b1;
  end

  assign dds_enable = (prescale_count == PRESCALE_LAST);

  // ------------------------------
  // DDS phase accumulator
  // ------------------------------

  // the increment comes straight from the rate table
  assign phase_inc = dds_increment(rate_select);

  // the accumulator wraps freely, so the top bit toggles at the output rate
  // with some jitter for increments that do not divide 2^DDS_BITS
  always_ff @(posedge clk)
  begin
    if (reset)
      phase <= '0;
    else if (dds_enable)
      phase <= phase + {1'b0, phase_inc};
  end

  assign phase_msb = phase[DDS_BITS-1];

  // ------------------------------
  // rising edge detector
  // ------------------------------

  // delayed copy of the top bit
  always_ff @(posedge clk)
  begin
    if (reset)
      phase_msb_d <= 1'b0;
    else
      phase_msb_d <= phase_msb;
  end

  // one clock wide enable on each rising edge of the top bit
  assign baud_tick = phase_msb & ~phase_msb_d;

endmodule

//--- verilog/rx_deframer.sv
module rx_deframer
  import uart_pkg::*;
#(
  parameter int DATA_BITS    = 8,
  parameter int STOP_BITS    = 1,
  parameter int CLOCK_FACTOR = 16
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 baud_tick,
  input  logic                 rxd,
  output logic                 word_done,
  output logic [DATA_BITS-1:0] frame_data,
  output logic                 error_over_run,
  output logic                 error_under_run,
  output logic                 error_all_low
);

  // one start bit, the data bits and the stop bits
  localparam int TOTAL_BITS = 1 + DATA_BITS + STOP_BITS;
  localparam int TICK_BITS  = $clog2(CLOCK_FACTOR);

  localparam logic [TICK_BITS-1:0] TICK_LAST = TICK_BITS'(CLOCK_FACTOR - 1);
  localparam logic [TICK_BITS-1:0] TICK_MID  = TICK_BITS'(CLOCK_FACTOR / 2);

  logic [TICK_BITS-1:0]  intrabit_count;
  logic                  mid_bit;
  logic [TOTAL_BITS-1:0] shifter;
  logic                  shifter_preset;
  logic                  frame_complete;
  logic                  stop_bit;
  logic                  all_low;
  rx_state_t             state;
  rx_state_t             state_next;

  // ------------------------------
  // intrabit counter
  // ------------------------------

  // held at zero while idle so counting starts at the falling start edge
  always_ff @(posedge clk)
  begin
    if (reset || shifter_preset)
      intrabit_count <= '0;
    else if (baud_tick)
    begin
      if (intrabit_count == TICK_LAST)
        intrabit_count <= '0;
      else
        intrabit_count <= intrabit_count + 1'b1;
    end
  end

  // one sample per bit, half a bit after the edge
  assign mid_bit = baud_tick && (intrabit_count == TICK_MID);

  // ------------------------------
  // receive shifter
  // ------------------------------

  // samples enter at the top and move down toward bit zero
  always_ff @(posedge clk)
  begin
    if (reset || shifter_preset)
      shifter <= '1;
    else if (mid_bit)
      shifter <= {rxd, shifter[TOTAL_BITS-1:1]};
  end

  // the start bit is the first zero to reach the bottom
  // once it lands there every preset one has been pushed out
  assign frame_complete = ~shifter[0];
  assign stop_bit       = shifter[TOTAL_BITS-1];
  assign all_low        = ~(|shifter);

  // data bits sit just above the start bit
  assign frame_data = shifter[DATA_BITS:1];

  // ------------------------------
  // receive state machine
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= rx_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next     = state;
    shifter_preset = 1'b0;
    case (state)
      rx_idle:
      begin
        shifter_preset = 1'b1;
        if (!rxd)
          state_next = rx_start;
      end
      rx_start:
      begin
        // a start bit that is gone by mid-bit was only a glitch
        if (mid_bit && rxd)
          state_next = rx_under_run;
        else if (mid_bit)
          state_next = rx_shift;
      end
      rx_shift:
      begin
        if (all_low)
          state_next = rx_all_low;
        else if (frame_complete && !stop_bit)
          state_next = rx_over_run;
        else if (frame_complete)
          state_next = rx_idle;
      end
      // the error states hold here until reset
      rx_over_run,
      rx_under_run,
      rx_all_low:
        shifter_preset = 1'b1;
      default:
        state_next = rx_idle;
    endcase
  end

  // a good frame ends on the sample of its final stop bit
  assign word_done = (state == rx_shift) && frame_complete && stop_bit;

  assign error_over_run  = (state == rx_over_run);
  assign error_under_run = (state == rx_under_run);
  assign error_all_low   = (state == rx_all_low);

endmodule

//--- verilog/rx_holding.sv
module rx_holding
  import uart_pkg::*;
#(
  parameter int DATA_BITS = 8
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 word_done,
  input  logic [DATA_BITS-1:0] frame_data,
  input  logic                 read,
  output logic [DATA_BITS-1:0] data,
  output logic                 data_ready
);

  hold_state_t state;

  // ------------------------------
  // output word register
  // ------------------------------

  // a new word replaces an unread one, there is no back-pressure
  always_ff @(posedge clk)
  begin
    if (word_done)
      data <= frame_data;
  end

  // ------------------------------
  // data ready flag
  // ------------------------------

  // a word arriving on the same clock as read keeps the flag set
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= hold_empty;
    else if (word_done)
      state <= hold_full;
    else if (read)
      state <= hold_empty;
  end

  assign data_ready = (state == hold_full);

endmodule

//--- verilog/uart_pkg.sv
package uart_pkg;

  // ------------------------------
  // baud generator sizing
  // ------------------------------

  // width of the DDS phase accumulator
  localparam int DDS_BITS = 6;

  // width of the prescale counter that feeds the DDS
  localparam int PRESCALE_BITS = 3;

  // the phase increment is one bit narrower than the accumulator
  typedef logic [DDS_BITS-2:0] dds_inc_t;

  // 3-bit index into the baud rate table
  typedef logic [2:0] rate_sel_t;

  // phase increments for a DDS clocked at the prescaled rate
  // entries 100 through 111 all give 115200 baud
  function automatic dds_inc_t dds_increment(input rate_sel_t rate);
    dds_inc_t inc;
    case (rate)
      3'b000:  inc = dds_inc_t'(1);
      3'b001:  inc = dds_inc_t'(2);
      3'b010:  inc = dds_inc_t'(4);
      3'b011:  inc = dds_inc_t'(6);
      default: inc = dds_inc_t'(12);
    endcase
    return inc;
  endfunction

  // ------------------------------
  // state encodings
  // ------------------------------

  // transmitter states, adjacent states differ in one bit
  typedef enum logic [1:0] {
    tx_idle             = 2'b00,
    tx_waiting          = 2'b01,
    tx_sending          = 2'b11,
    tx_sending_last_bit = 2'b10
  } tx_state_t;

  // receiver states, the three error states are sticky until reset
  typedef enum logic [2:0] {
    rx_idle      = 3'd0,
    rx_start     = 3'd1,
    rx_shift     = 3'd3,
    rx_over_run  = 3'd2,
    rx_under_run = 3'd4,
    rx_all_low   = 3'd5
  } rx_state_t;

  // data ready flag of the receive holding register
  typedef enum logic {
    hold_empty = 1'b0,
    hold_full  = 1'b1
  } hold_state_t;

endpackage

//--- verilog/uart_top.sv
module uart_top
  import uart_pkg::*;
#(
  parameter int DATA_BITS     = 8,
  parameter int STOP_BITS     = 1,
  parameter int CLOCK_FACTOR  = 16,
  parameter int PRESCALE_NDIV = 5
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  rate_sel_t            rate_select,
  input  logic                 load,
  input  logic [DATA_BITS-1:0] tx_data,
  output logic                 load_request,
  output logic                 txd,
  input  logic                 rxd,
  input  logic                 read,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 data_ready,
  output logic                 error_over_run,
  output logic                 error_under_run,
  output logic                 error_all_low
);

  // oversampling enable shared by both directions
  logic                 baud_tick;
  // handoff from the deframer to the holding register
  logic                 word_done;
  logic [DATA_BITS-1:0] frame_data;

  baud_gen #(
    .PRESCALE_NDIV (PRESCALE_NDIV)
  ) u_baud_gen (
    .clk         (clk),
    .reset       (reset),
    .rate_select (rate_select),
    .baud_tick   (baud_tick)
  );

  uart_tx #(
    .DATA_BITS    (DATA_BITS),
    .STOP_BITS    (STOP_BITS),
    .CLOCK_FACTOR (CLOCK_FACTOR)
  ) u_uart_tx (
    .clk          (clk),
    .reset        (reset),
    .baud_tick    (baud_tick),
    .load         (load),
    .data         (tx_data),
    .load_request (load_request),
    .txd          (txd)
  );

  rx_deframer #(
    .DATA_BITS    (DATA_BITS),
    .STOP_BITS    (STOP_BITS),
    .CLOCK_FACTOR (CLOCK_FACTOR)
  ) u_rx_deframer (
    .clk             (clk),
    .reset           (reset),
    .baud_tick       (baud_tick),
    .rxd             (rxd),
    .word_done       (word_done),
    .frame_data      (frame_data),
    .error_over_run  (error_over_run),
    .error_under_run (error_under_run),
    .error_all_low   (error_all_low)
  );

  rx_holding #(
    .DATA_BITS (DATA_BITS)
  ) u_rx_holding (
    .clk        (clk),
    .reset      (reset),
    .word_done  (word_done),
    .frame_data (frame_data),
    .read       (read),
    .data       (rx_data),
    .data_ready (data_ready)
  );

endmodule

//--- verilog/uart_tx.sv
module uart_tx
  import uart_pkg::*;
#(
  parameter int DATA_BITS    = 8,
  parameter int STOP_BITS    = 1,
  parameter int CLOCK_FACTOR = 16
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 baud_tick,
  input  logic                 load,
  input  logic [DATA_BITS-1:0] data,
  output logic                 load_request,
  output logic                 txd
);

  // one start bit, the data bits and the stop bits
  localparam int TOTAL_BITS = 1 + DATA_BITS + STOP_BITS;
  localparam int TICK_BITS  = $clog2(CLOCK_FACTOR);
  localparam int COUNT_BITS = $clog2(TOTAL_BITS);

  localparam logic [TICK_BITS-1:0]  TICK_LAST  = TICK_BITS'(CLOCK_FACTOR - 1);
  localparam logic [COUNT_BITS-1:0] COUNT_LAST = COUNT_BITS'(TOTAL_BITS - 2);

  logic [TICK_BITS-1:0]  tick_count;
  logic                  bit_strobe;
  logic [COUNT_BITS-1:0] bit_count;
  logic                  begin_last_bit;
  logic [DATA_BITS-1:0]  holding;
  logic [DATA_BITS-1:0]  next_word;
  logic [TOTAL_BITS-1:0] tx_word;
  logic [TOTAL_BITS-1:0] shifter;
  logic                  start_sending;
  tx_state_t             state;
  tx_state_t             state_next;

  // ------------------------------
  // bit rate divider
  // ------------------------------

  // counts baud ticks within one bit time
  always_ff @(posedge clk)
  begin
    if (reset)
      tick_count <= '0;
    else if (baud_tick)
    begin
      if (tick_count == TICK_LAST)
        tick_count <= '0;
      else
        tick_count <= tick_count + 1'b1;
    end
  end

  // one clock strobe at every bit boundary
  assign bit_strobe = baud_tick && (tick_count == TICK_LAST);

  // ------------------------------
  // bit counter
  // ------------------------------

  // cleared when a frame starts, so it marks the start of the final bit
  always_ff @(posedge clk)
  begin
    if (reset || start_sending)
      bit_count <= '0;
    else if (bit_strobe)
    begin
      if (bit_count == COUNT_LAST)
        bit_count <= '0;
      else
        bit_count <= bit_count + 1'b1;
    end
  end

  assign begin_last_bit = bit_strobe && (bit_count == COUNT_LAST);

  // ------------------------------
  // holding register
  // ------------------------------

  // a later load simply overwrites a word that has not started yet
  always_ff @(posedge clk)
  begin
    if (load)
      holding <= data;
  end

  // bypass the holding register when load and the start strobe coincide
  assign next_word = load ? data : holding;
  assign tx_word   = {{STOP_BITS{1'b1}}, next_word, 1'b0};

  // a frame starts on a strobe if a word is pending or arrives just then
  assign start_sending = bit_strobe && ((state == tx_waiting) || (load_request && load));

  // ------------------------------
  // transmit state machine
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= tx_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next   = state;
    load_request = 1'b0;
    case (state)
      tx_idle:
      begin
        load_request = 1'b1;
        if (load && bit_strobe)
          state_next = tx_sending;
        else if (load)
          state_next = tx_waiting;
      end
      tx_waiting:
      begin
        if (bit_strobe)
          state_next = tx_sending;
      end
      tx_sending:
      begin
        if (begin_last_bit)
          state_next = tx_sending_last_bit;
      end
      tx_sending_last_bit:
      begin
        // the strobe that ends the last stop bit frees the transmitter
        load_request = bit_strobe;
        if (bit_strobe && load)
          state_next = tx_sending;
        else if (bit_strobe)
          state_next = tx_idle;
        else if (load)
          // word pending, it goes out right behind this frame
          state_next = tx_waiting;
      end
      default:
        state_next = tx_idle;
    endcase
  end

  // ------------------------------
  // transmit shifter
  // ------------------------------

  // least significant bit goes out first, ones fill in behind the frame
  always_ff @(posedge clk)
  begin
    if (reset)
      shifter <= '1;
    else if (start_sending)
      shifter <= tx_word;
    else if (bit_strobe)
      shifter <= {1'b1, shifter[TOTAL_BITS-1:1]};
  end

  // the line idles high
  assign txd = shifter[0];

endmodule
